// File: design/matcalc_pkg.sv
`default_nettype none

package matcalc_pkg;

    // ======================================================================
    // Matrix geometry
    // ======================================================================
    localparam int MAX_DIM   = 5;
    localparam int MAX_ELEMS = MAX_DIM * MAX_DIM;
    localparam int ELEM_W    = 16;

    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [2:0]        dim_t;
    // Flat index, row * MAX_DIM + col
    typedef logic [4:0]        idx_t;

    // ======================================================================
    // Control states
    // ======================================================================
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_INPUT_DIM,
        ST_INPUT_DATA,
        ST_PRINT
    } ctrl_state_t;

    // ASCII bytes shared by parser and printer
    localparam logic [7:0] ASCII_SPACE = 8'h20;
    localparam logic [7:0] ASCII_LF    = 8'h0A;
    localparam logic [7:0] ASCII_ZERO  = 8'h30;

endpackage

`default_nettype wire

// File: design/mat_port_if.sv
`timescale 1ns/1ps
`default_nettype none

// Write port into the matrix store
interface mat_wr_if import matcalc_pkg::*; ();
    dim_t  row;
    dim_t  col;
    elem_t data;
    logic  we;
    dim_t  dim_m;
    dim_t  dim_n;
    logic  dim_we;

    modport source (
        output row, col, data, we,
        output dim_m, dim_n, dim_we
    );

    modport target (
        input row, col, data, we,
        input dim_m, dim_n, dim_we
    );
endinterface

// Read port, element data returned without a clock
interface mat_rd_if import matcalc_pkg::*; ();
    dim_t  row;
    dim_t  col;
    elem_t data;
    dim_t  m;
    dim_t  n;

    modport sink (
        output row, col,
        input  data, m, n
    );

    modport source (
        input  row, col,
        output data, m, n
    );
endinterface

`default_nettype wire

// File: design/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT) + 1;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        rx_state;
    logic [1:0]       sync;
    logic             rxd_s;
    logic [CNT_W-1:0] clk_cnt;
    logic             half_end;
    logic             bit_end;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_reg;

    assign rxd_s    = sync[1];
    assign half_end = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign rx_data  = shift_reg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync     <= 2'b11;
            rx_state <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync     <= {sync[0], rxd};
            rx_valid <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_s) rx_state <= RX_START;
                end
                // Recheck the line at the middle of the start bit
                RX_START: begin
                    if (half_end) begin
                        clk_cnt  <= '0;
                        bit_idx  <= '0;
                        rx_state <= rxd_s ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) rx_state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        rx_valid <= rxd_s;  // bad stop bit drops the byte
                        rx_state <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk) begin
        if (rx_state == RX_DATA && bit_end) shift_reg <= {rxd_s, shift_reg[7:1]};
    end

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       txd,
    output logic       tx_busy
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT) + 1;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t        tx_state;
    logic [CNT_W-1:0] clk_cnt;
    logic             bit_end;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_reg;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_state <= TX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            txd      <= 1'b1;
            tx_busy  <= 1'b0;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (tx_state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    if (tx_start) begin
                        txd      <= 1'b0;
                        tx_busy  <= 1'b1;
                        tx_state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        txd      <= shift_reg[0];
                        bit_idx  <= '0;
                        tx_state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            txd      <= 1'b1;
                            tx_state <= TX_STOP;
                        end else begin
                            txd <= shift_reg[1];
                        end
                    end
                end
                // Busy stays up until the stop bit is complete
                TX_STOP: begin
                    if (bit_end) begin
                        tx_busy  <= 1'b0;
                        tx_state <= TX_IDLE;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_state == TX_IDLE && tx_start) begin
            shift_reg <= tx_data;
        end else if (tx_state == TX_DATA && bit_end) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

`default_nettype wire

// File: design/num_parser.sv
`timescale 1ns/1ps
`default_nettype none

module num_parser import matcalc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output elem_t      number,
    output logic       number_valid
);
    logic [7:0] digit;
    logic       is_digit;
    elem_t      acc;
    logic       seen;

    assign digit    = rx_data - ASCII_ZERO;
    assign is_digit = (rx_data >= ASCII_ZERO) && (digit <= 8'd9);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc          <= '0;
            seen         <= 1'b0;
            number_valid <= 1'b0;
        end else begin
            number_valid <= 1'b0;
            if (rx_valid) begin
                if (is_digit) begin
                    // Wraps at 16 bits on long digit runs
                    acc  <= acc * elem_t'(10) + {8'd0, digit};
                    seen <= 1'b1;
                end else if (seen) begin
                    number_valid <= 1'b1;
                    acc          <= '0;
                    seen         <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && !is_digit && seen) number <= acc;
    end

endmodule

`default_nettype wire

// File: design/matrix_store.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_store import matcalc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    mat_wr_if.target wr,
    mat_rd_if.source rd
);
    elem_t mem [MAX_ELEMS];
    dim_t  dim_m;
    dim_t  dim_n;
    idx_t  wr_idx;
    idx_t  rd_idx;

    // Fixed 5-wide row pitch regardless of n
    assign wr_idx = idx_t'(wr.row) * idx_t'(MAX_DIM) + idx_t'(wr.col);
    assign rd_idx = idx_t'(rd.row) * idx_t'(MAX_DIM) + idx_t'(rd.col);

    always_ff @(posedge clk) begin
        if (wr.we) mem[wr_idx] <= wr.data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dim_m <= '0;
            dim_n <= '0;
        end else if (wr.dim_we) begin
            dim_m <= wr.dim_m;
            dim_n <= wr.dim_n;
        end
    end

    assign rd.data = mem[rd_idx];
    assign rd.m    = dim_m;
    assign rd.n    = dim_n;

endmodule

`default_nettype wire

// File: design/entry_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module entry_ctrl import matcalc_pkg::*; #(
    parameter int ERR_HOLD_CYCLES = 100_000_000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        btn,
    input  elem_t       number,
    input  logic        number_valid,
    input  logic        print_done,
    mat_wr_if.source    wr,
    output logic        print_start,
    output logic        err_led,
    output ctrl_state_t state
);
    localparam int ERR_W = $clog2(ERR_HOLD_CYCLES + 1);

    logic [2:0]       btn_sync;
    logic             btn_rise;
    dim_t             dim_m;
    dim_t             dim_n;
    idx_t             total;
    idx_t             count;
    idx_t             clr_cnt;
    logic             clearing;
    logic [ERR_W-1:0] err_cnt;
    logic             dim_ok;
    logic             elem_ok;
    logic             data_phase;

    assign btn_rise   = btn_sync[1] & ~btn_sync[2];
    assign err_led    = (err_cnt != '0);
    assign dim_ok     = (number >= elem_t'(1)) && (number <= elem_t'(MAX_DIM));
    assign elem_ok    = (number <= elem_t'(9));
    assign data_phase = (state == ST_INPUT_DATA) && !clearing && !err_led;

    // Two sync stages plus one for the edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) btn_sync <= '0;
        else        btn_sync <= {btn_sync[1:0], btn};
    end

    // ======================================================================
    // Memory write port
    // ======================================================================
    always_comb begin
        wr.data = '0;
        if (clearing) begin
            wr.row = dim_t'(clr_cnt / idx_t'(MAX_DIM));
            wr.col = dim_t'(clr_cnt % idx_t'(MAX_DIM));
            wr.we  = 1'b1;
        end else begin
            // Flat count split by the column count
            wr.row  = dim_t'(count / idx_t'(dim_n));
            wr.col  = dim_t'(count % idx_t'(dim_n));
            wr.data = number;
            wr.we   = data_phase && number_valid && elem_ok && !btn_rise;
        end
        wr.dim_m  = dim_m;
        wr.dim_n  = dim_t'(number);
        wr.dim_we = (state == ST_INPUT_DIM) && !err_led && number_valid && dim_ok
                    && (dim_m != '0);
    end

    // ======================================================================
    // Control FSM and error hold
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            dim_m       <= '0;
            dim_n       <= 3'd1;
            total       <= '0;
            count       <= '0;
            clr_cnt     <= '0;
            clearing    <= 1'b0;
            err_cnt     <= '0;
            print_start <= 1'b0;
        end else begin
            print_start <= 1'b0;
            if (err_led) err_cnt <= err_cnt - 1'b1;

            case (state)
                ST_IDLE: begin
                    if (btn_rise) begin
                        dim_m <= '0;
                        state <= ST_INPUT_DIM;
                    end
                end
                ST_INPUT_DIM: begin
                    if (!err_led && number_valid) begin
                        if (!dim_ok) begin
                            err_cnt <= ERR_W'(ERR_HOLD_CYCLES);
                            dim_m   <= '0;
                        end else if (dim_m == '0) begin
                            dim_m <= dim_t'(number);
                        end else begin
                            dim_n    <= dim_t'(number);
                            total    <= idx_t'(dim_m) * idx_t'(number);
                            count    <= '0;
                            clr_cnt  <= '0;
                            clearing <= 1'b1;
                            state    <= ST_INPUT_DATA;
                        end
                    end
                end
                ST_INPUT_DATA: begin
                    if (err_led) begin
                        // Bad element aborts once the hold ends
                        if (err_cnt == ERR_W'(1)) state <= ST_IDLE;
                    end else if (clearing) begin
                        clr_cnt <= clr_cnt + idx_t'(1);
                        if (clr_cnt == idx_t'(MAX_ELEMS - 1)) clearing <= 1'b0;
                    end else if (btn_rise) begin
                        print_start <= 1'b1;
                        state       <= ST_PRINT;
                    end else if (number_valid) begin
                        if (!elem_ok) begin
                            err_cnt <= ERR_W'(ERR_HOLD_CYCLES);
                        end else begin
                            count <= count + idx_t'(1);
                            if (count + idx_t'(1) == total) begin
                                print_start <= 1'b1;
                                state       <= ST_PRINT;
                            end
                        end
                    end
                end
                ST_PRINT: begin
                    if (print_done) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/matrix_printer.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_printer import matcalc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       print_start,
    mat_rd_if.sink     rd,
    output logic [7:0] tx_data,
    output logic       tx_start,
    input  logic       tx_busy,
    output logic       print_done
);
    localparam elem_t TEN = elem_t'(10);

    typedef enum logic [2:0] {
        P_IDLE,
        P_LOAD,
        P_DIV,
        P_DIGIT,
        P_SEP,
        P_DONE
    } pr_state_t;

    pr_state_t  pr_state;
    dim_t       row;
    dim_t       col;
    dim_t       last_row;
    dim_t       last_col;
    elem_t      value;
    logic [3:0] digits [5];
    logic [2:0] ndig;
    logic       tx_ready;

    assign rd.row   = row;
    assign rd.col   = col;
    assign last_row = rd.m - 3'd1;
    assign last_col = rd.n - 3'd1;
    // busy only rises the cycle after a start
    assign tx_ready = !tx_busy && !tx_start;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pr_state   <= P_IDLE;
            row        <= '0;
            col        <= '0;
            ndig       <= '0;
            tx_start   <= 1'b0;
            print_done <= 1'b0;
        end else begin
            tx_start   <= 1'b0;
            print_done <= 1'b0;
            case (pr_state)
                P_IDLE: begin
                    if (print_start) begin
                        row      <= '0;
                        col      <= '0;
                        pr_state <= P_LOAD;
                    end
                end
                P_LOAD: begin
                    ndig     <= '0;
                    pr_state <= P_DIV;
                end
                // One digit per cycle, least significant first
                P_DIV: begin
                    ndig <= ndig + 3'd1;
                    if (value < TEN) pr_state <= P_DIGIT;
                end
                P_DIGIT: begin
                    if (tx_ready) begin
                        tx_start <= 1'b1;
                        ndig     <= ndig - 3'd1;
                        if (ndig == 3'd1) pr_state <= P_SEP;
                    end
                end
                P_SEP: begin
                    if (tx_ready) begin
                        tx_start <= 1'b1;
                        if (col == last_col) begin
                            col <= '0;
                            if (row == last_row) begin
                                pr_state <= P_DONE;
                            end else begin
                                row      <= row + 3'd1;
                                pr_state <= P_LOAD;
                            end
                        end else begin
                            col      <= col + 3'd1;
                            pr_state <= P_LOAD;
                        end
                    end
                end
                // Wait out the final line feed
                P_DONE: begin
                    if (tx_ready) begin
                        print_done <= 1'b1;
                        pr_state   <= P_IDLE;
                    end
                end
                default: pr_state <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (pr_state)
            P_LOAD: value <= rd.data;
            P_DIV: begin
                digits[ndig] <= 4'(value % TEN);
                value        <= value / TEN;
            end
            P_DIGIT: begin
                if (tx_ready) tx_data <= ASCII_ZERO + {4'd0, digits[ndig - 3'd1]};
            end
            P_SEP: begin
                if (tx_ready) tx_data <= (col == last_col) ? ASCII_LF : ASCII_SPACE;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/matcalc_top.sv
`timescale 1ns/1ps
`default_nettype none

module matcalc_top import matcalc_pkg::*; #(
    parameter int CLKS_PER_BIT    = 868,
    parameter int ERR_HOLD_CYCLES = 100_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rxd,
    output logic       uart_txd,
    input  logic       btn,
    output logic       err_led,
    output logic [1:0] state
);
    // ======================================================================
    // Serial input and number parsing
    // ======================================================================
    logic [7:0] rx_data;
    logic       rx_valid;
    elem_t      number;
    logic       number_valid;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rxd      (uart_rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    num_parser u_parser (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .number       (number),
        .number_valid (number_valid)
    );

    // ======================================================================
    // Entry control and storage
    // ======================================================================
    mat_wr_if wr_bus ();
    mat_rd_if rd_bus ();

    logic print_start;
    logic print_done;

    entry_ctrl #(.ERR_HOLD_CYCLES(ERR_HOLD_CYCLES)) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .btn          (btn),
        .number       (number),
        .number_valid (number_valid),
        .print_done   (print_done),
        .wr           (wr_bus),
        .print_start  (print_start),
        .err_led      (err_led),
        .state        (state)
    );

    matrix_store u_store (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr_bus),
        .rd    (rd_bus)
    );

    // ======================================================================
    // Print-back
    // ======================================================================
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    matrix_printer u_printer (
        .clk         (clk),
        .rst_n       (rst_n),
        .print_start (print_start),
        .rd          (rd_bus),
        .tx_data     (tx_data),
        .tx_start    (tx_start),
        .tx_busy     (tx_busy),
        .print_done  (print_done)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .txd      (uart_txd),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

// File: tests/tb_matcalc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_matcalc import matcalc_pkg::*; ();

    logic       clk;
    logic       rst_n;
    logic       uart_rxd;
    logic       uart_txd;
    logic       btn;
    logic       err_led;
    logic [1:0] state;

    logic [31:0] rng_state;
    string       test_name;
    int          elems [25];
    logic [7:0]  exp_q [$];
    logic [7:0]  tx_q [$];
    logic [7:0]  mon_byte;
    logic [7:0]  got_byte;

    // Bytes sent plus bytes printed with random entries counted at the 5x5 maximum
    localparam int DIRECTED_BYTES = 79;
    localparam int RANDOM_BYTES   = 8 * (54 + 50);
    localparam int HOLD_CLKS      = 2 * 300;
    localparam int LIMIT_CLKS     = 2 * ((DIRECTED_BYTES + RANDOM_BYTES) * 10 * 8 + HOLD_CLKS);

    matcalc_top #(.CLKS_PER_BIT(8), .ERR_HOLD_CYCLES(300)) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .btn      (btn),
        .err_led  (err_led),
        .state    (state)
    );

    always #50 clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAIL %s: expected 0x%0h, actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_below(input int range);
        rng_state = lcg_next(rng_state);
        return int'(rng_state[30:16]) % range;
    endfunction

    // Expected print in decimal with spaces and a line feed per row
    function automatic void format_matrix(input int m, input int n);
        int r;
        int c;
        int v;
        int nd;
        int k;
        logic [7:0] digs [5];
        for (r = 0; r < m; r++) begin
            for (c = 0; c < n; c++) begin
                v = elems[r * n + c];
                digs[0] = 8'h30 + 8'(v % 10);
                nd = 1;
                v = v / 10;
                while (v != 0) begin
                    digs[nd] = 8'h30 + 8'(v % 10);
                    nd++;
                    v = v / 10;
                end
                for (k = nd - 1; k >= 0; k--) exp_q.push_back(digs[k]);
                exp_q.push_back((c == n - 1) ? 8'h0A : 8'h20);
            end
        end
    endfunction

    // 8N1 frame at 8 clocks per bit and a short idle gap
    task automatic send_byte(input logic [7:0] b);
        int i;
        @(negedge clk);
        uart_rxd = 1'b0;
        repeat (8) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            uart_rxd = b[i];
            repeat (8) @(negedge clk);
        end
        uart_rxd = 1'b1;
        repeat (12) @(negedge clk);
    endtask

    // Values in these tests stay below 100
    task automatic send_number(input int v);
        if (v >= 10) send_byte(8'h30 + 8'(v / 10));
        send_byte(8'h30 + 8'(v % 10));
        send_byte(8'h20);
    endtask

    task automatic press_button();
        @(negedge clk);
        btn = 1'b1;
        repeat (4) @(negedge clk);
        btn = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic wait_print();
        while (exp_q.size() != 0 || state != ST_IDLE) @(negedge clk);
    endtask

    task automatic enter_matrix(input int m, input int n, input int count);
        int k;
        press_button();
        send_number(m);
        send_number(n);
        for (k = 0; k < count; k++) send_number(elems[k]);
    endtask

    // ======================================================================
    // TX monitor and comparison
    // ======================================================================
    always begin
        @(negedge uart_txd);
        repeat (4) @(negedge clk);
        if (uart_txd !== 1'b0) abort_run("Start bit on uart_txd was too short");
        for (int i = 0; i < 8; i++) begin
            repeat (8) @(negedge clk);
            mon_byte[i] = uart_txd;
        end
        repeat (8) @(negedge clk);
        if (uart_txd !== 1'b1) abort_run("Stop bit missing on uart_txd");
        tx_q.push_back(mon_byte);
    end

    always @(posedge clk) begin
        while (tx_q.size() != 0) begin
            got_byte = tx_q.pop_front();
            if (exp_q.size() == 0) begin
                abort_run($sformatf("Unexpected byte 0x%02h on uart_txd during %s",
                                    got_byte, test_name));
            end else begin
                check_value({test_name, " tx byte"}, exp_q.pop_front(), got_byte);
            end
        end
    end

    initial begin
        repeat (LIMIT_CLKS) @(posedge clk);
        abort_run("Timeout: the tests did not finish in time");
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        int m;
        int n;
        int t;
        int k;
        clk        = 1'b0;
        rst_n      = 1'b0;
        uart_rxd   = 1'b1;
        btn        = 1'b0;
        rng_state  = 32'hbb9e;
        test_name  = "reset";
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset state", ST_IDLE, state);
        check_value("reset err_led", 1'b0, err_led);
        check_value("reset uart_txd", 1'b1, uart_txd);

        test_name = "full entry";
        for (k = 0; k < 6; k++) elems[k] = (k * 7 + 3) % 10;
        format_matrix(2, 3);
        enter_matrix(2, 3, 6);
        wait_print();

        // Four elements and the rest of the 3x3 stays cleared
        test_name = "manual finish";
        for (k = 0; k < 25; k++) elems[k] = 0;
        elems[0] = 5;
        elems[1] = 8;
        elems[2] = 1;
        elems[3] = 6;
        format_matrix(3, 3);
        enter_matrix(3, 3, 4);
        press_button();
        wait_print();

        test_name = "bad dimension";
        press_button();
        send_number(7);
        check_value("bad dimension err_led", 1'b1, err_led);
        check_value("bad dimension state", ST_INPUT_DIM, state);
        while (err_led) @(negedge clk);
        check_value("bad dimension state after hold", ST_INPUT_DIM, state);
        elems[0] = 4;
        elems[1] = 9;
        format_matrix(1, 2);
        send_number(1);
        send_number(2);
        send_number(4);
        send_number(9);
        wait_print();

        test_name = "bad element";
        enter_matrix(2, 2, 0);
        send_number(12);
        check_value("bad element err_led", 1'b1, err_led);
        check_value("bad element state during hold", ST_INPUT_DATA, state);
        while (err_led) @(negedge clk);
        @(negedge clk);
        check_value("bad element state after hold", ST_IDLE, state);
        check_value("bad element uart_txd", 1'b1, uart_txd);

        for (t = 0; t < 8; t++) begin
            test_name = $sformatf("random %0d", t);
            m = 1 + rand_below(5);
            n = 1 + rand_below(5);
            for (k = 0; k < m * n; k++) elems[k] = rand_below(10);
            format_matrix(m, n);
            enter_matrix(m, n, m * n);
            wait_print();
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: matcalc.f
design/matcalc_pkg.sv
design/mat_port_if.sv
design/uart_rx.sv
design/uart_tx.sv
design/num_parser.sv
design/matrix_store.sv
design/entry_ctrl.sv
design/matrix_printer.sv
design/matcalc_top.sv
tests/tb_matcalc.sv
